// File: verilog/la32_pkg.sv
`default_nettype none

package la32_pkg;

    typedef enum logic [2:0] {
        ST_IF,
        ST_ID,
        ST_EXE,
        ST_MEM,
        ST_WB
    } state_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // Behaviour class, used by control for branches and strobes.
    typedef enum logic [2:0] {
        CL_ALU,
        CL_LOAD,
        CL_STORE,
        CL_BCOND,
        CL_JUMP,
        CL_JIRL,
        CL_INVALID
    } inst_class_e;

endpackage

`default_nettype wire

// File: verilog/la32_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module la32_decoder import la32_pkg::*; (
    input  wire  [31:0] inst_word,
    output inst_class_e inst_class,
    output alu_op_e     alu_op,
    output logic        src1_is_pc,
    output logic        src2_is_imm,
    output logic        src2_is_rd,
    output logic [31:0] imm,
    output logic [31:0] br_offs,
    output logic        beq_not_bne,
    output logic [4:0]  rf_dest,
    output logic        rf_wen_req
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  ui5;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;

    assign op_31_26 = inst_word[31:26];
    assign op_25_22 = inst_word[25:22];
    assign op_21_20 = inst_word[21:20];
    assign op_19_15 = inst_word[19:15];
    assign rd       = inst_word[4:0];
    assign ui5      = inst_word[14:10];
    assign i12      = inst_word[21:10];
    assign i20      = inst_word[24:5];
    assign i16      = inst_word[25:10];
    assign i26      = {inst_word[9:0], inst_word[25:10]};

    // b and bl carry the long offset, all other branches the short one.
    assign br_offs = (op_31_26 == 6'h14 || op_31_26 == 6'h15) ?
                     {{4{i26[25]}}, i26, 2'b00} : {{14{i16[15]}}, i16, 2'b00};

    always_comb begin
        inst_class  = CL_INVALID;
        alu_op      = ALU_ADD;
        src1_is_pc  = 1'b0;
        src2_is_imm = 1'b0;
        src2_is_rd  = 1'b0;
        imm         = {{20{i12[11]}}, i12};
        beq_not_bne = 1'b0;
        rf_dest     = rd;
        rf_wen_req  = 1'b0;

        case (op_31_26)
            6'h00: begin
                if (op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
                    inst_class = CL_ALU;
                    case (op_19_15)
                        5'h00:   alu_op = ALU_ADD;
                        5'h02:   alu_op = ALU_SUB;
                        5'h04:   alu_op = ALU_SLT;
                        5'h05:   alu_op = ALU_SLTU;
                        5'h08:   alu_op = ALU_NOR;
                        5'h09:   alu_op = ALU_AND;
                        5'h0a:   alu_op = ALU_OR;
                        5'h0b:   alu_op = ALU_XOR;
                        default: inst_class = CL_INVALID;
                    endcase
                end else if (op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
                    inst_class  = CL_ALU;
                    src2_is_imm = 1'b1;
                    imm         = {27'b0, ui5};
                    case (op_19_15)
                        5'h01:   alu_op = ALU_SLL;
                        5'h09:   alu_op = ALU_SRL;
                        5'h11:   alu_op = ALU_SRA;
                        default: inst_class = CL_INVALID;
                    endcase
                end else if (op_25_22 == 4'ha) begin
                    inst_class  = CL_ALU;
                    src2_is_imm = 1'b1;
                end
            end
            6'h05: begin
                if (!inst_word[25]) begin
                    inst_class  = CL_ALU;
                    alu_op      = ALU_LUI;
                    src2_is_imm = 1'b1;
                    imm         = {i20, 12'b0};
                end
            end
            6'h0a: begin
                if (op_25_22 == 4'h2) begin
                    inst_class  = CL_LOAD;
                    src2_is_imm = 1'b1;
                end else if (op_25_22 == 4'h6) begin
                    inst_class  = CL_STORE;
                    src2_is_imm = 1'b1;
                    src2_is_rd  = 1'b1;
                end
            end
            6'h13: begin
                // Link value pc+4 comes out of the ALU.
                inst_class  = CL_JIRL;
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                imm         = 32'd4;
            end
            6'h14: inst_class = CL_JUMP;
            6'h15: begin
                inst_class  = CL_JUMP;
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                imm         = 32'd4;
                rf_dest     = 5'd1;
                rf_wen_req  = 1'b1;
            end
            6'h16, 6'h17: begin
                inst_class  = CL_BCOND;
                src2_is_rd  = 1'b1;
                beq_not_bne = ~inst_word[26];
            end
            default: ;
        endcase

        if (inst_class == CL_ALU || inst_class == CL_LOAD || inst_class == CL_JIRL) begin
            rf_wen_req = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/la32_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module la32_regfile (
    input  wire         clk,
    input  wire  [4:0]  raddr1,
    input  wire  [4:0]  raddr2,
    input  wire         we,
    input  wire  [4:0]  waddr,
    input  wire  [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] rf [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // Entry zero is never written and always reads back as zero.
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

`default_nettype wire

// File: verilog/la32_alu.sv
`timescale 1ns/1ps
`default_nettype none

module la32_alu import la32_pkg::*; (
    input  alu_op_e     alu_op,
    input  wire  [31:0] alu_src1,
    input  wire  [31:0] alu_src2,
    output logic [31:0] alu_result
);

    logic [4:0] shamt;

    assign shamt = alu_src2[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = alu_src1 + alu_src2;
            ALU_SUB:  alu_result = alu_src1 - alu_src2;
            ALU_SLT:  alu_result = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
            ALU_SLTU: alu_result = {31'b0, alu_src1 < alu_src2};
            ALU_AND:  alu_result = alu_src1 & alu_src2;
            ALU_NOR:  alu_result = ~(alu_src1 | alu_src2);
            ALU_OR:   alu_result = alu_src1 | alu_src2;
            ALU_XOR:  alu_result = alu_src1 ^ alu_src2;
            ALU_SLL:  alu_result = alu_src1 << shamt;
            ALU_SRL:  alu_result = alu_src1 >> shamt;
            ALU_SRA:  alu_result = $signed(alu_src1) >>> shamt;
            // Upper immediate is already shifted by the decoder.
            ALU_LUI:  alu_result = alu_src2;
            default:  alu_result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/la32_control.sv
`timescale 1ns/1ps
`default_nettype none

module la32_control import la32_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  wire         clk,
    input  wire         reset,
    input  wire  [31:0] inst_sram_rdata,
    input  wire  [31:0] data_sram_rdata,
    input  inst_class_e inst_class,
    input  wire  [31:0] alu_result,
    input  wire  [31:0] rj_value,
    input  wire  [31:0] rkd_value,
    input  wire  [31:0] br_offs,
    input  wire         beq_not_bne,
    input  wire         src2_is_rd,
    input  wire  [4:0]  rf_dest,
    input  wire         rf_wen_req,
    output logic [31:0] pc,
    output logic [31:0] inst_word,
    output logic [31:0] inst_sram_addr,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    output logic [4:0]  rf_raddr1,
    output logic [4:0]  rf_raddr2,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    state_e      state;
    logic [31:0] exe_result;
    logic [31:0] br_target;
    logic        br_taken;
    logic        take_now;

    always_comb begin
        case (inst_class)
            CL_BCOND:         take_now = ((rj_value == rkd_value) == beq_not_bne);
            CL_JUMP, CL_JIRL: take_now = 1'b1;
            default:          take_now = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IF;
            pc       <= RESET_PC;
            br_taken <= 1'b0;
        end else begin
            case (state)
                ST_IF:  state <= ST_ID;
                ST_ID:  state <= ST_EXE;
                ST_EXE: begin
                    state    <= ST_MEM;
                    br_taken <= take_now;
                end
                ST_MEM: state <= ST_WB;
                ST_WB: begin
                    state <= ST_IF;
                    pc    <= br_taken ? br_target : pc + 32'd4;
                end
                default: state <= ST_IF;
            endcase
        end
    end

    // Fetch data arrives one cycle after the address, so it is taken in decode.
    always_ff @(posedge clk) begin
        if (state == ST_ID) begin
            inst_word <= inst_sram_rdata;
        end
        if (state == ST_EXE) begin
            exe_result <= alu_result;
            br_target  <= (inst_class == CL_JIRL) ? rj_value + br_offs : pc + br_offs;
        end
    end

    assign rf_raddr1 = inst_word[9:5];
    assign rf_raddr2 = src2_is_rd ? inst_word[4:0] : inst_word[14:10];

    assign inst_sram_addr  = pc;
    assign data_sram_we    = (state == ST_MEM) && (inst_class == CL_STORE);
    assign data_sram_addr  = exe_result;
    assign data_sram_wdata = rkd_value;

    // Load data is valid in write-back, one cycle after the memory state.
    assign rf_we    = (state == ST_WB) && rf_wen_req;
    assign rf_waddr = rf_dest;
    assign rf_wdata = (inst_class == CL_LOAD) ? data_sram_rdata : exe_result;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

// File: verilog/la32_core.sv
`timescale 1ns/1ps
`default_nettype none

module la32_core import la32_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  wire         clk,
    input  wire         reset,
    output logic [31:0] inst_sram_addr,
    input  wire  [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  wire  [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    inst_class_e inst_class;
    alu_op_e     alu_op;
    logic [31:0] pc;
    logic [31:0] inst_word;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic        src2_is_rd;
    logic [31:0] imm;
    logic [31:0] br_offs;
    logic        beq_not_bne;
    logic [4:0]  rf_dest;
    logic        rf_wen_req;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;

    assign alu_src1 = src1_is_pc ? pc : rj_value;
    assign alu_src2 = src2_is_imm ? imm : rkd_value;

    la32_control #(
        .RESET_PC (RESET_PC)
    ) u_control (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_rdata   (data_sram_rdata),
        .inst_class        (inst_class),
        .alu_result        (alu_result),
        .rj_value          (rj_value),
        .rkd_value         (rkd_value),
        .br_offs           (br_offs),
        .beq_not_bne       (beq_not_bne),
        .src2_is_rd        (src2_is_rd),
        .rf_dest           (rf_dest),
        .rf_wen_req        (rf_wen_req),
        .pc                (pc),
        .inst_word         (inst_word),
        .inst_sram_addr    (inst_sram_addr),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .rf_raddr1         (rf_raddr1),
        .rf_raddr2         (rf_raddr2),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    la32_decoder u_decoder (
        .inst_word   (inst_word),
        .inst_class  (inst_class),
        .alu_op      (alu_op),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .src2_is_rd  (src2_is_rd),
        .imm         (imm),
        .br_offs     (br_offs),
        .beq_not_bne (beq_not_bne),
        .rf_dest     (rf_dest),
        .rf_wen_req  (rf_wen_req)
    );

    la32_regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rj_value),
        .rdata2 (rkd_value)
    );

    la32_alu u_alu (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

endmodule

`default_nettype wire

// File: tests/la32_checker.sv
`timescale 1ns/1ps
`default_nettype none

module la32_checker #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  wire         clk,
    input  wire         reset,
    input  wire  [31:0] inst_sram_addr,
    input  wire  [31:0] inst_sram_rdata,
    input  wire         data_sram_we,
    input  wire  [31:0] data_sram_addr,
    input  wire  [31:0] data_sram_wdata,
    input  wire  [31:0] debug_wb_pc,
    input  wire  [3:0]  debug_wb_rf_we,
    input  wire  [4:0]  debug_wb_rf_wnum,
    input  wire  [31:0] debug_wb_rf_wdata,
    output int          retired,
    output int          errors,
    output logic [31:0] done_pc
);

    logic [31:0] xr [32];
    logic [31:0] dmem [256];
    logic [31:0] ref_pc;
    logic [31:0] ref_pc_at;
    logic [31:0] inst_q;
    logic        exp_we;
    logic [4:0]  exp_wnum;
    logic [31:0] exp_wdata;
    logic        exp_st;
    logic [31:0] exp_addr;
    logic [31:0] exp_sdata;
    logic        st_now;
    logic        wr_now;
    int          cnt;
    int          phase;

    // Executes one instruction on the model state and returns the next pc.
    function automatic logic [31:0] ref_step(input logic [31:0] pc, input logic [31:0] inst);
        logic [4:0]  rd;
        logic [31:0] vj;
        logic [31:0] vk;
        logic [31:0] vd;
        logic [31:0] s12;
        logic [31:0] off16;
        logic [31:0] off26;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] nxt;
        logic        wr;
        rd    = inst[4:0];
        vj    = xr[inst[9:5]];
        vk    = xr[inst[14:10]];
        vd    = xr[inst[4:0]];
        s12   = {{20{inst[21]}}, inst[21:10]};
        off16 = {{14{inst[25]}}, inst[25:10], 2'b00};
        off26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        addr  = vj + s12;
        nxt   = pc + 32'd4;
        res   = 32'd0;
        wr    = 1'b1;
        exp_st = 1'b0;
        if (inst[31:20] == 12'h001) begin
            case (inst[19:15])
                5'h00:   res = vj + vk;
                5'h02:   res = vj - vk;
                5'h04:   res = ($signed(vj) < $signed(vk)) ? 32'd1 : 32'd0;
                5'h05:   res = (vj < vk) ? 32'd1 : 32'd0;
                5'h08:   res = ~(vj | vk);
                5'h09:   res = vj & vk;
                5'h0a:   res = vj | vk;
                5'h0b:   res = vj ^ vk;
                default: wr = 1'b0;
            endcase
        end else if (inst[31:15] == 17'h00081) begin
            res = vj << inst[14:10];
        end else if (inst[31:15] == 17'h00089) begin
            res = vj >> inst[14:10];
        end else if (inst[31:15] == 17'h00091) begin
            res = $signed(vj) >>> inst[14:10];
        end else if (inst[31:22] == 10'h00a) begin
            res = addr;
        end else if (inst[31:25] == 7'h0a) begin
            res = {inst[24:5], 12'h000};
        end else if (inst[31:22] == 10'h0a2) begin
            res = dmem[addr[9:2]];
        end else if (inst[31:22] == 10'h0a6) begin
            wr        = 1'b0;
            exp_st    = 1'b1;
            exp_addr  = addr;
            exp_sdata = vd;
            dmem[addr[9:2]] = vd;
        end else if (inst[31:26] == 6'h13) begin
            res = pc + 32'd4;
            nxt = vj + off16;
        end else if (inst[31:26] == 6'h14) begin
            wr  = 1'b0;
            nxt = pc + off26;
        end else if (inst[31:26] == 6'h15) begin
            rd  = 5'd1;
            res = pc + 32'd4;
            nxt = pc + off26;
        end else if (inst[31:27] == 5'h0b) begin
            // beq on bit 26 clear, bne on bit 26 set.
            wr = 1'b0;
            if ((vj == vd) != inst[26]) begin
                nxt = pc + off16;
            end
        end else begin
            wr = 1'b0;
        end
        exp_we    = wr;
        exp_wnum  = rd;
        exp_wdata = res;
        if (wr && rd != 5'd0) begin
            xr[rd] = res;
        end
        return nxt;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        errors++;
    endtask

    task automatic report_event(input string what);
        $display("Error at %0t: %s (model pc %h)", $time, what, ref_pc_at);
        errors++;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            cnt     = 0;
            retired = 0;
            errors  = 0;
            ref_pc  = RESET_PC;
            done_pc = RESET_PC;
            exp_st  = 1'b0;
            exp_we  = 1'b0;
            for (int i = 0; i < 32; i++) begin
                xr[i] = 32'd0;
            end
            for (int i = 0; i < 256; i++) begin
                dmem[i] = 32'd0;
            end
        end else begin
            phase = cnt % 5;
            if (phase == 0 && inst_sram_addr !== ref_pc) begin
                report_mismatch("inst_sram_addr", ref_pc, inst_sram_addr);
            end
            if (phase == 1) begin
                inst_q = inst_sram_rdata;
            end
            if (phase == 3) begin
                ref_pc_at = ref_pc;
                ref_pc    = ref_step(ref_pc, inst_q);
            end

            st_now = (phase == 3) && exp_st;
            if (data_sram_we !== st_now) begin
                report_event(st_now ? "expected store did not occur" :
                                      "store occurred outside an expected store");
            end else if (st_now) begin
                if (data_sram_addr !== exp_addr)
                    report_mismatch("data_sram_addr", exp_addr, data_sram_addr);
                if (data_sram_wdata !== exp_sdata)
                    report_mismatch("data_sram_wdata", exp_sdata, data_sram_wdata);
            end

            wr_now = (phase == 4) && exp_we;
            if (debug_wb_rf_we !== {4{wr_now}}) begin
                report_event(wr_now ? "expected register write did not occur" :
                                      "register write occurred outside an expected write");
            end else if (wr_now) begin
                if (debug_wb_pc !== ref_pc_at)
                    report_mismatch("debug_wb_pc", ref_pc_at, debug_wb_pc);
                if (debug_wb_rf_wnum !== exp_wnum)
                    report_mismatch("debug_wb_rf_wnum", {27'd0, exp_wnum},
                                    {27'd0, debug_wb_rf_wnum});
                if (debug_wb_rf_wdata !== exp_wdata)
                    report_mismatch("debug_wb_rf_wdata", exp_wdata, debug_wb_rf_wdata);
            end

            if (phase == 4) begin
                retired++;
                done_pc = ref_pc;
            end
            cnt++;
        end
    end

endmodule

`default_nettype wire

// File: tests/la32_tb.sv
`timescale 1ns/1ps
`default_nettype none

module la32_tb;

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    int          retired;
    int          errors;
    logic [31:0] done_pc;

    logic [31:0] prog [256];
    logic [31:0] dmem [256];
    logic [31:0] inst_addr_q;
    logic [31:0] data_addr_q;
    logic [31:0] fetch_idx;
    int          prog_len = 0;
    bit          prog_ready = 1'b0;
    int          sec_end [5];
    string       sec_name [5];

    always #5 clk = ~clk;

    la32_core #(
        .RESET_PC (RESET_PC)
    ) u_la32_core (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    la32_checker #(
        .RESET_PC (RESET_PC)
    ) u_checker (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .retired           (retired),
        .errors            (errors),
        .done_pc           (done_pc)
    );

    // Both SRAMs take the address on the rising edge and answer on the falling edge.
    always @(posedge clk) begin
        inst_addr_q <= inst_sram_addr;
        data_addr_q <= data_sram_addr;
        if (data_sram_we === 1'b1) begin
            dmem[data_sram_addr[9:2]] = data_sram_wdata;
        end
    end

    always @(negedge clk) begin
        fetch_idx = (inst_addr_q - RESET_PC) >> 2;
        inst_sram_rdata = (fetch_idx < prog_len) ? prog[fetch_idx[7:0]] : 32'd0;
        data_sram_rdata = dmem[data_addr_q[9:2]];
    end

    function automatic logic [31:0] enc_reg3(input logic [31:0] base, input logic [4:0] rd,
                                             input logic [4:0] rj, input logic [4:0] rk);
        return base | {17'd0, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_imm12(input logic [31:0] base, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [11:0] imm);
        return base | {10'd0, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_off16(input logic [31:0] base, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [15:0] offs);
        return base | {6'd0, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_off26(input logic [31:0] base, input logic [25:0] offs);
        return base | {6'd0, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] enc_lu12i(input logic [4:0] rd, input logic [19:0] imm);
        return 32'h1400_0000 | {7'd0, imm, rd};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    function automatic logic [4:0] pick_reg(input int lo, input int span);
        return 5'(lo + int'($urandom % span));
    endfunction

    task automatic build_program();
        logic [31:0] alu_base [9];
        logic [31:0] shift_base [3];
        logic [31:0] tgt;
        int          k;
        alu_base = '{32'h0010_0000, 32'h0011_0000, 32'h0012_0000, 32'h0012_8000,
                     32'h0014_0000, 32'h0014_8000, 32'h0015_0000, 32'h0015_8000,
                     32'h0280_0000};
        shift_base = '{32'h0040_8000, 32'h0044_8000, 32'h0048_8000};
        for (int r = 1; r < 16; r++) begin
            emit(enc_lu12i(5'(r), 20'($urandom)));
            emit(enc_imm12(32'h0280_0000, 5'(r), 5'(r), 12'($urandom)));
        end
        sec_end[0] = prog_len;
        for (int i = 0; i < 40; i++) begin
            k = int'($urandom % 9);
            if (k == 8)
                emit(enc_imm12(alu_base[8], pick_reg(1, 15), pick_reg(0, 16), 12'($urandom)));
            else
                emit(enc_reg3(alu_base[k], pick_reg(1, 15), pick_reg(0, 16), pick_reg(0, 16)));
        end
        sec_end[1] = prog_len;
        for (int i = 0; i < 12; i++) begin
            emit(enc_reg3(shift_base[i % 3], pick_reg(1, 15), pick_reg(1, 15), 5'($urandom)));
        end
        emit(enc_imm12(32'h0280_0000, 5'd0, 5'd5, 12'd7));
        emit(enc_reg3(32'h0010_0000, 5'd6, 5'd0, 5'd0));
        emit(enc_lu12i(5'd7, 20'($urandom)));
        emit(enc_reg3(32'h0011_0000, 5'd8, 5'd0, 5'd7));
        sec_end[2] = prog_len;
        emit(enc_imm12(32'h0280_0000, 5'd20, 5'd0, 12'h100));
        emit(enc_imm12(32'h2980_0000, 5'd3, 5'd20, 12'd8));
        emit(enc_imm12(32'h2880_0000, 5'd21, 5'd20, 12'd8));
        emit(enc_imm12(32'h2980_0000, 5'd4, 5'd20, 12'hffc));
        emit(enc_imm12(32'h2880_0000, 5'd25, 5'd20, 12'hffc));
        emit(enc_imm12(32'h2880_0000, 5'd26, 5'd20, 12'd8));
        sec_end[3] = prog_len;
        for (int i = 0; i < 4; i++) begin
            // beq, bne, bne, beq, each skipping one marker when taken.
            emit(enc_off16((i == 1 || i == 2) ? 32'h5c00_0000 : 32'h5800_0000, 5'd1,
                           (i < 2) ? 5'd1 : 5'd2, 16'd2));
            emit(enc_imm12(32'h0280_0000, 5'd22, 5'd0, 12'(i + 1)));
        end
        emit(enc_off26(32'h5000_0000, 26'd2));
        emit(enc_imm12(32'h0280_0000, 5'd22, 5'd0, 12'd5));
        emit(enc_off26(32'h5400_0000, 26'd2));
        emit(enc_imm12(32'h0280_0000, 5'd22, 5'd0, 12'd6));
        tgt = RESET_PC + 32'(4 * (prog_len + 4));
        emit(enc_lu12i(5'd24, 20'((tgt + 32'h800) >> 12)));
        emit(enc_imm12(32'h0280_0000, 5'd24, 5'd24, tgt[11:0]));
        emit(enc_off16(32'h4c00_0000, 5'd23, 5'd24, 16'd0));
        emit(enc_imm12(32'h0280_0000, 5'd22, 5'd0, 12'd7));
        emit(enc_imm12(32'h0280_0000, 5'd22, 5'd23, 12'd0));
        sec_end[4] = prog_len;
    endtask

    initial begin
        reset = 1'b1;
        inst_sram_rdata = 32'd0;
        data_sram_rdata = 32'd0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'd0;
        end
        sec_name = '{"register init", "random alu", "shift and upper immediate",
                     "store and load", "branches"};
        void'($urandom(32'h91c7_36e2));
        build_program();
        prog_ready = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        for (int s = 0; s < 5; s++) begin
            wait (done_pc >= RESET_PC + 32'(4 * sec_end[s]));
            $display("Section %s finished, %0d errors so far", sec_name[s], errors);
        end
        $display("Totals: %0d instructions retired, %0d errors", retired, errors);
        if (errors == 0 && retired > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        wait (prog_ready);
        #((prog_len + 10) * 50);
        $display("Timeout: the program did not complete in the expected number of cycles");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: la32_core.f
verilog/la32_pkg.sv
verilog/la32_decoder.sv
verilog/la32_regfile.sv
verilog/la32_alu.sv
verilog/la32_control.sv
verilog/la32_core.sv
tests/la32_checker.sv
tests/la32_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the la32 testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f la32_core.f --top-module la32_tb -Mdir obj_dir

./obj_dir/Vla32_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
